// File: simd_cfg.svh
/*
 * Packed-SIMD add/subtract unit configuration
 * Word and lane geometry plus the APB register map
 */
`ifndef SIMD_CFG_SVH
`define SIMD_CFG_SVH

// Datapath geometry
`define SIMD_DATA_W       32
`define SIMD_LANE_W       8
`define SIMD_LANES        4

// APB address width
`define SIMD_APB_ADDR_W   8

// Register byte addresses
`define SIMD_ADDR_OPA     8'h00
`define SIMD_ADDR_OPB     8'h04
`define SIMD_ADDR_CTRL    8'h08
`define SIMD_ADDR_RESULT  8'h0C
`define SIMD_ADDR_STATUS  8'h10

`endif

// File: simd_pkg.sv
/*
 * Packed-SIMD add/subtract unit types
 * Operation, element width and arithmetic mode encodings, data words and lane masks
 */
`include "simd_cfg.svh"

package simd_pkg;

  typedef logic [`SIMD_DATA_W-1:0] simd_word_t;
  typedef logic [`SIMD_LANE_W-1:0] simd_lane_t;

  // CTRL bits 2:0
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_CMPEQ = 3'd2,
    OP_CMPLT = 3'd3,
    OP_MIN   = 3'd4,
    OP_MAX   = 3'd5
  } simd_op_e;

  // CTRL bits 5:4
  typedef enum logic [1:0] {
    W8  = 2'd0,
    W16 = 2'd1,
    W32 = 2'd2
  } simd_width_e;

  // CTRL bits 9:8 for add and subtract only
  typedef enum logic [1:0] {
    MODE_WRAP  = 2'd0,
    MODE_SAT   = 2'd1,
    MODE_HALVE = 2'd2
  } simd_mode_e;

  // Lanes holding the least significant byte of an element
  function automatic logic [`SIMD_LANES-1:0] low_lane_mask(simd_width_e width);
    case (width)
      W8:      return 4'b1111;
      W16:     return 4'b0101;
      default: return 4'b0001;
    endcase
  endfunction

  // Lanes holding the most significant byte of an element
  function automatic logic [`SIMD_LANES-1:0] top_lane_mask(simd_width_e width);
    case (width)
      W8:      return 4'b1111;
      W16:     return 4'b1010;
      default: return 4'b1000;
    endcase
  endfunction

endpackage

// File: simd_apb_regs.sv
/*
 * SIMD unit APB register block
 * Operand and control registers, result capture, done and sticky overflow status
 */
`timescale 1ns/10ps
`include "simd_cfg.svh"

module simd_apb_regs import simd_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [`SIMD_APB_ADDR_W-1:0] paddr_i,
  input  simd_word_t                  pwdata_i,
  output simd_word_t                  prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,

  input  simd_word_t                  result_i,
  input  logic                        overflow_i,

  output simd_word_t                  opa_o,
  output simd_word_t                  opb_o,
  output simd_op_e                    op_o,
  output simd_width_e                 width_o,
  output logic                        signed_o,
  output simd_mode_e                  mode_o
);

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////
  logic access, mapped, wr_en, ovf_clr;
  logic sel_opa, sel_opb, sel_ctrl, sel_result, sel_status;

  assign access     = psel_i & penable_i;
  assign sel_opa    = (paddr_i == `SIMD_ADDR_OPA);
  assign sel_opb    = (paddr_i == `SIMD_ADDR_OPB);
  assign sel_ctrl   = (paddr_i == `SIMD_ADDR_CTRL);
  assign sel_result = (paddr_i == `SIMD_ADDR_RESULT);
  assign sel_status = (paddr_i == `SIMD_ADDR_STATUS);
  assign mapped     = sel_opa | sel_opb | sel_ctrl | sel_result | sel_status;

  // RESULT is read-only
  assign wr_en   = access & pwrite_i & mapped & ~sel_result;
  assign ovf_clr = wr_en & sel_status & pwdata_i[0];

  // Zero wait states
  assign pready_o  = access;
  assign pslverr_o = access & (~mapped | (pwrite_i & sel_result));

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////
  simd_word_t  opa_q, opb_q, result_q;
  simd_op_e    op_q;
  simd_width_e width_q;
  simd_mode_e  mode_q;
  logic        signed_q, busy_q, done_q, ovf_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      opa_q    <= '0;
      opb_q    <= '0;
      op_q     <= OP_ADD;
      width_q  <= W8;
      signed_q <= 1'b0;
      mode_q   <= MODE_WRAP;
      result_q <= '0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      ovf_q    <= 1'b0;
    end else begin
      if (wr_en & sel_opa) begin
        opa_q <= pwdata_i;
      end
      if (wr_en & sel_opb) begin
        opb_q <= pwdata_i;
      end
      if (wr_en & sel_ctrl) begin
        op_q     <= simd_op_e'(pwdata_i[2:0]);
        width_q  <= simd_width_e'(pwdata_i[5:4]);
        signed_q <= pwdata_i[6];
        mode_q   <= simd_mode_e'(pwdata_i[9:8]);
      end
      // Result settles the cycle after CTRL is written
      busy_q <= wr_en & sel_ctrl;
      if (busy_q) begin
        result_q <= result_i;
      end
      if (wr_en & sel_ctrl) begin
        done_q <= 1'b0;
      end else if (busy_q) begin
        done_q <= 1'b1;
      end
      ovf_q <= (ovf_q & ~ovf_clr) | (busy_q & overflow_i);
    end
  end

  // Read mux gated onto prdata in the access phase of a read
  simd_word_t rd_data;

  always_comb begin
    case (paddr_i)
      `SIMD_ADDR_OPA:    rd_data = opa_q;
      `SIMD_ADDR_OPB:    rd_data = opb_q;
      `SIMD_ADDR_CTRL:   rd_data = {{(`SIMD_DATA_W-10){1'b0}}, mode_q, 1'b0, signed_q,
                                    width_q, 1'b0, op_q};
      `SIMD_ADDR_RESULT: rd_data = result_q;
      `SIMD_ADDR_STATUS: rd_data = {{(`SIMD_DATA_W-2){1'b0}}, done_q, ovf_q};
      default:           rd_data = '0;
    endcase
  end

  assign prdata_o = (access & ~pwrite_i) ? rd_data : '0;

  assign opa_o    = opa_q;
  assign opb_o    = opb_q;
  assign op_o     = op_q;
  assign width_o  = width_q;
  assign signed_o = signed_q;
  assign mode_o   = mode_q;

endmodule

// File: simd_lane_ctrl.sv
/*
 * SIMD lane controller
 * Turns the control register into per-lane B inversion, carry-in, chaining and sign controls
 */
`timescale 1ns/10ps
`include "simd_cfg.svh"

module simd_lane_ctrl import simd_pkg::*; (
  input  simd_word_t              opb_i,
  input  simd_op_e                op_i,
  input  simd_width_e             width_i,
  input  logic                    signed_i,
  input  simd_mode_e              mode_i,

  output simd_word_t              lane_b_o,
  output logic [`SIMD_LANES-1:0]  cin_o,
  output logic [`SIMD_LANES-1:0]  chain_o,
  output logic [`SIMD_LANES-1:0]  top_signed_o
);

  logic                   invert_b, use_ext;
  logic [`SIMD_LANES-1:0] low, top;

  // Everything but add computes A - B
  always_comb begin
    case (op_i)
      OP_SUB, OP_CMPEQ, OP_CMPLT, OP_MIN, OP_MAX: invert_b = 1'b1;
      default:                                    invert_b = 1'b0;
    endcase
  end

  // Operations that read the extended sum bit of the top lane
  always_comb begin
    case (op_i)
      OP_ADD, OP_SUB:           use_ext = (mode_i != MODE_WRAP);
      OP_CMPLT, OP_MIN, OP_MAX: use_ext = 1'b1;
      default:                  use_ext = 1'b0;
    endcase
  end

  assign low = low_lane_mask(width_i);
  assign top = top_lane_mask(width_i);

  // Two's complement negate via inverted B and carry-in of one
  assign lane_b_o = invert_b ? ~opb_i : opb_i;
  assign cin_o    = low & {`SIMD_LANES{invert_b}};

  // Upper lanes of an element ripple from the lane below
  assign chain_o  = ~low;

  assign top_signed_o = top & {`SIMD_LANES{signed_i & use_ext}};

endmodule

// File: simd_byte_lane.sv
/*
 * SIMD byte lane
 * 8-bit adder slice with carry chaining, extended sum bit and zero detect
 */
`timescale 1ns/10ps
`include "simd_cfg.svh"

module simd_byte_lane import simd_pkg::*; (
  input  simd_lane_t  a_i,
  input  simd_lane_t  b_i,
  input  logic        carry_i,
  input  logic        cin_i,
  input  logic        chain_i,
  input  logic        top_signed_i,

  output simd_lane_t  sum_o,
  output logic        ext_o,
  output logic        carry_o,
  output logic        zero_o
);

  logic                  carry_in;
  logic [`SIMD_LANE_W:0] raw_sum;

  // Ripple from the lower lane or start a new element
  assign carry_in = chain_i ? carry_i : cin_i;

  assign raw_sum = {1'b0, a_i} + {1'b0, b_i} + {{`SIMD_LANE_W{1'b0}}, carry_in};

  assign sum_o   = raw_sum[`SIMD_LANE_W-1:0];
  assign carry_o = raw_sum[`SIMD_LANE_W];

  // Ninth bit of the sign-extended sum
  // equals sign(a) ^ sign(b) ^ carry out for a signed element
  assign ext_o = top_signed_i ?
                 (a_i[`SIMD_LANE_W-1] ^ b_i[`SIMD_LANE_W-1] ^ carry_o) : carry_o;

  assign zero_o = (sum_o == '0);

endmodule

// File: simd_result_merge.sv
/*
 * SIMD result merge
 * Builds per-element results for wrap, saturate, halve, compare and min/max
 */
`timescale 1ns/10ps
`include "simd_cfg.svh"

module simd_result_merge import simd_pkg::*; (
  input  simd_word_t              opa_i,
  input  simd_word_t              opb_i,
  input  simd_word_t              sum_i,
  input  logic [`SIMD_LANES-1:0]  ext_i,
  input  logic [`SIMD_LANES-1:0]  zero_i,
  input  simd_op_e                op_i,
  input  simd_width_e             width_i,
  input  logic                    signed_i,
  input  simd_mode_e              mode_i,

  output simd_word_t              result_o,
  output logic                    overflow_o
);

  localparam int LW = `SIMD_LANE_W;

  logic [`SIMD_LANES-1:0] top, elem_ext, elem_msb, elem_eq, elem_lt, sat_hit;
  logic                   is_sub, arith;
  simd_word_t             shifted, sat_res, halve_res, eq_res, lt_res, min_res, max_res;

  assign top     = top_lane_mask(width_i);
  assign is_sub  = (op_i == OP_SUB);
  assign arith   = (op_i == OP_ADD) | is_sub;
  assign shifted = sum_i >> 1;

  //////////////////////////////////////////////////////////////////////
  // Element flags spread over all lanes of the element
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    int unsigned t;
    logic        eq;
    for (int b = 0; b < `SIMD_LANES; b++) begin
      case (width_i)
        W8: begin
          t  = b;
          eq = zero_i[b];
        end
        W16: begin
          t  = b | 1;
          eq = zero_i[b & ~1] & zero_i[b | 1];
        end
        default: begin
          t  = `SIMD_LANES - 1;
          eq = &zero_i;
        end
      endcase
      elem_ext[b] = ext_i[t];
      elem_msb[b] = sum_i[LW*t + LW-1];
      elem_eq[b]  = eq;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Per-lane results
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    logic       half_top;
    simd_lane_t clamp;
    for (int b = 0; b < `SIMD_LANES; b++) begin
      // Unsigned difference has its true ninth bit inverted from the carry
      half_top = elem_ext[b] ^ (is_sub & ~signed_i);
      halve_res[LW*b +: LW] = {top[b] ? half_top : shifted[LW*b + LW-1],
                               shifted[LW*b +: LW-1]};

      if (signed_i) begin
        // Ninth and eighth bits disagree on signed overflow
        sat_hit[b] = elem_ext[b] ^ elem_msb[b];
        clamp      = top[b] ? {elem_ext[b], {(LW-1){~elem_ext[b]}}} : {LW{~elem_ext[b]}};
      end else begin
        // Carry on add, borrow on subtract
        sat_hit[b] = elem_ext[b] ^ is_sub;
        clamp      = {LW{~is_sub}};
      end
      sat_res[LW*b +: LW] = sat_hit[b] ? clamp : sum_i[LW*b +: LW];

      // A < B from the sign of A - B
      elem_lt[b] = signed_i ? elem_ext[b] : ~elem_ext[b];

      eq_res[LW*b +: LW]  = {LW{elem_eq[b]}};
      lt_res[LW*b +: LW]  = {LW{elem_lt[b]}};
      min_res[LW*b +: LW] = elem_lt[b] ? opa_i[LW*b +: LW] : opb_i[LW*b +: LW];
      max_res[LW*b +: LW] = elem_lt[b] ? opb_i[LW*b +: LW] : opa_i[LW*b +: LW];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (op_i)
      OP_ADD, OP_SUB: begin
        case (mode_i)
          MODE_SAT:   result_o = sat_res;
          MODE_HALVE: result_o = halve_res;
          default:    result_o = sum_i;
        endcase
      end
      OP_CMPEQ: result_o = eq_res;
      OP_CMPLT: result_o = lt_res;
      OP_MIN:   result_o = min_res;
      OP_MAX:   result_o = max_res;
      default:  result_o = sum_i;
    endcase
  end

  assign overflow_o = arith & (mode_i == MODE_SAT) & (|sat_hit);

endmodule

// File: simd_alu_top.sv
/*
 * Packed-SIMD add/subtract unit top level
 * APB registers, lane controller, four byte lanes and result merge
 */
`timescale 1ns/10ps
`include "simd_cfg.svh"

module simd_alu_top import simd_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [`SIMD_APB_ADDR_W-1:0] paddr_i,
  input  simd_word_t                  pwdata_i,
  output simd_word_t                  prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o
);

  simd_word_t             opa, opb, lane_b, sum, result;
  simd_op_e               op;
  simd_width_e            width;
  simd_mode_e             mode;
  logic                   is_signed, overflow;
  logic [`SIMD_LANES-1:0] cin, chain, top_signed, ext, carry, carry_in, zero;

  //////////////////////////////////////////////////////////////////////
  // Registers and lane control
  //////////////////////////////////////////////////////////////////////
  simd_apb_regs u_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .result_i   (result),
    .overflow_i (overflow),
    .opa_o      (opa),
    .opb_o      (opb),
    .op_o       (op),
    .width_o    (width),
    .signed_o   (is_signed),
    .mode_o     (mode)
  );

  simd_lane_ctrl u_ctrl (
    .opb_i        (opb),
    .op_i         (op),
    .width_i      (width),
    .signed_i     (is_signed),
    .mode_i       (mode),
    .lane_b_o     (lane_b),
    .cin_o        (cin),
    .chain_o      (chain),
    .top_signed_o (top_signed)
  );

  //////////////////////////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////////////////////////
  // Lane 0 never chains
  assign carry_in = {carry[`SIMD_LANES-2:0], 1'b0};

  for (genvar i = 0; i < `SIMD_LANES; i++) begin : g_lane
    simd_byte_lane u_lane (
      .a_i          (opa[`SIMD_LANE_W*i +: `SIMD_LANE_W]),
      .b_i          (lane_b[`SIMD_LANE_W*i +: `SIMD_LANE_W]),
      .carry_i      (carry_in[i]),
      .cin_i        (cin[i]),
      .chain_i      (chain[i]),
      .top_signed_i (top_signed[i]),
      .sum_o        (sum[`SIMD_LANE_W*i +: `SIMD_LANE_W]),
      .ext_o        (ext[i]),
      .carry_o      (carry[i]),
      .zero_o       (zero[i])
    );
  end

  simd_result_merge u_merge (
    .opa_i      (opa),
    .opb_i      (opb),
    .sum_i      (sum),
    .ext_i      (ext),
    .zero_i     (zero),
    .op_i       (op),
    .width_i    (width),
    .signed_i   (is_signed),
    .mode_i     (mode),
    .result_o   (result),
    .overflow_o (overflow)
  );

endmodule

// File: simd_alu_chk.sv
/*
 * Protocol checker for the SIMD APB register block
 * Bound into the register block to flag pready, pslverr and done misbehavior
 */
`timescale 1ns/10ps
`include "simd_cfg.svh"

module simd_alu_chk (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        psel_i,
  input logic                        penable_i,
  input logic                        pwrite_i,
  input logic [`SIMD_APB_ADDR_W-1:0] paddr_i,
  input logic                        pready_i,
  input logic                        pslverr_i,
  input logic                        done_i
);

  logic access, mapped, bad_access, ctrl_wr;
  int   fail_count = 0;

  assign access     = psel_i & penable_i;
  assign mapped     = (paddr_i == `SIMD_ADDR_OPA) | (paddr_i == `SIMD_ADDR_OPB) |
                      (paddr_i == `SIMD_ADDR_CTRL) | (paddr_i == `SIMD_ADDR_RESULT) |
                      (paddr_i == `SIMD_ADDR_STATUS);
  assign bad_access = access & (~mapped | (pwrite_i & (paddr_i == `SIMD_ADDR_RESULT)));
  assign ctrl_wr    = access & pwrite_i & (paddr_i == `SIMD_ADDR_CTRL);

  // Zero wait state slave
  a_pready: assert property (@(posedge clk_i) disable iff (!rst_n_i) access |-> pready_i)
    else begin
      $error("pready low during an APB access phase");
      fail_count++;
    end

  // Done drops after the CTRL write and returns one cycle later
  a_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                           ctrl_wr |=> !done_i ##1 done_i)
    else begin
      $error("done did not fall and rise one cycle after a CTRL write");
      fail_count++;
    end

  a_slverr_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  pslverr_i |-> bad_access)
    else begin
      $error("pslverr raised on a legal access");
      fail_count++;
    end

  a_slverr_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                 bad_access |-> pslverr_i)
    else begin
      $error("pslverr missing on an unmapped access or RESULT write");
      fail_count++;
    end

endmodule

bind simd_apb_regs simd_alu_chk u_chk (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pwrite_i  (pwrite_i),
  .paddr_i   (paddr_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .done_i    (done_q)
);

// File: simd_alu_tb.sv
/*
 * Testbench for the packed-SIMD add/subtract unit
 * Drives APB transfers and checks results against a reference model
 */
`timescale 1ns/10ps
`include "simd_cfg.svh"

module simd_alu_tb import simd_pkg::*; ();

  localparam int TIMEOUT = 64;

  logic                        clk_i, rst_n_i, psel_i, penable_i, pwrite_i;
  logic [`SIMD_APB_ADDR_W-1:0] paddr_i;
  simd_word_t                  pwdata_i, prdata_o, last_exp;
  logic                        pready_o, pslverr_o, last_slverr, model_ovf;
  logic [31:0]                 lcg_state;

  // Pending comparisons from the stimulus side
  simd_word_t got_q[$];
  simd_word_t exp_q[$];
  bit         is_flag_q[$];
  string      tag_q[$];

  simd_alu_top uut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string tag, input simd_word_t got, input simd_word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, tag, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string tag, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, tag, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic enqueue_word(input string tag, input simd_word_t got, input simd_word_t exp);
    got_q.push_back(got);
    exp_q.push_back(exp);
    is_flag_q.push_back(1'b0);
    tag_q.push_back(tag);
  endtask

  task automatic enqueue_flag(input string tag, input logic got, input logic exp);
    got_q.push_back({31'd0, got});
    exp_q.push_back({31'd0, exp});
    is_flag_q.push_back(1'b1);
    tag_q.push_back(tag);
  endtask

  // Full-period LCG constants with the better bits at the top
  function automatic simd_word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bytes biased toward the range limits
  function automatic simd_word_t edge_word();
    simd_word_t w, r;
    for (int k = 0; k < `SIMD_LANES; k++) begin
      r = lcg_next();
      case (r[18:16])
        3'd0:    w[8*k +: 8] = 8'h00;
        3'd1:    w[8*k +: 8] = 8'h7F;
        3'd2:    w[8*k +: 8] = 8'h80;
        3'd3:    w[8*k +: 8] = 8'hFF;
        3'd4:    w[8*k +: 8] = 8'h01;
        3'd5:    w[8*k +: 8] = 8'hFE;
        default: w[8*k +: 8] = r[31:24];
      endcase
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model working element by element in full precision
  //////////////////////////////////////////////////////////////////////
  function automatic simd_word_t ref_result(input simd_word_t a, input simd_word_t b,
                                            input simd_op_e op, input simd_width_e w,
                                            input logic sgn, input simd_mode_e mode,
                                            output logic ovf);
    int          ew;
    longint      mask, hi, lo, ea, eb, r;
    logic [63:0] wa, wb;
    simd_word_t  res;
    ew   = (w == W8) ? 8 : ((w == W16) ? 16 : 32);
    mask = (longint'(1) << ew) - 1;
    hi   = sgn ? (mask >> 1) : mask;
    lo   = sgn ? (-(mask >> 1) - 1) : 0;
    res  = '0;
    ovf  = 1'b0;
    for (int e = 0; e < `SIMD_DATA_W / ew; e++) begin
      wa = {32'd0, a} >> (e * ew);
      wb = {32'd0, b} >> (e * ew);
      ea = wa & mask;
      eb = wb & mask;
      // Two's complement view of the element
      if (sgn && ea[ew-1]) begin
        ea = ea - mask - 1;
      end
      if (sgn && eb[ew-1]) begin
        eb = eb - mask - 1;
      end
      case (op)
        OP_ADD, OP_SUB: begin
          r = (op == OP_ADD) ? (ea + eb) : (ea - eb);
          if (mode == MODE_SAT && r > hi) begin
            r   = hi;
            ovf = 1'b1;
          end else if (mode == MODE_SAT && r < lo) begin
            r   = lo;
            ovf = 1'b1;
          end else if (mode == MODE_HALVE) begin
            r = r >>> 1;
          end
        end
        OP_CMPEQ: r = (ea == eb) ? -1 : 0;
        OP_CMPLT: r = (ea < eb) ? -1 : 0;
        OP_MIN:   r = (ea < eb) ? ea : eb;
        default:  r = (ea < eb) ? eb : ea;
      endcase
      res = res | (simd_word_t'(r & mask) << (e * ew));
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // APB driver
  //////////////////////////////////////////////////////////////////////
  task automatic apb_access(input logic [`SIMD_APB_ADDR_W-1:0] addr, input logic write,
                            input simd_word_t wdata, output simd_word_t rdata);
    int waited;
    waited = 0;
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(posedge clk_i);
    while (!pready_o) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("APB access to address %h never saw pready", addr);
        stop_with_failure();
      end
      @(posedge clk_i);
    end
    rdata       = prdata_o;
    last_slverr = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [`SIMD_APB_ADDR_W-1:0] addr, input simd_word_t data);
    simd_word_t unused;
    apb_access(addr, 1'b1, data, unused);
  endtask

  task automatic apb_read(input logic [`SIMD_APB_ADDR_W-1:0] addr, output simd_word_t data);
    apb_access(addr, 1'b0, '0, data);
  endtask

  task automatic wait_done();
    simd_word_t status;
    int         polls;
    polls = 0;
    apb_read(`SIMD_ADDR_STATUS, status);
    while (!status[1]) begin
      polls++;
      if (polls > TIMEOUT) begin
        $display("Timed out waiting for the done bit in STATUS");
        stop_with_failure();
      end
      apb_read(`SIMD_ADDR_STATUS, status);
    end
  endtask

  task automatic run_op(input simd_word_t a, input simd_word_t b, input simd_op_e op,
                        input simd_width_e w, input logic sgn, input simd_mode_e mode);
    simd_word_t got, exp;
    logic       ovf;
    apb_write(`SIMD_ADDR_OPA, a);
    apb_write(`SIMD_ADDR_OPB, b);
    apb_write(`SIMD_ADDR_CTRL, {22'd0, mode, 1'b0, sgn, w, 1'b0, op});
    wait_done();
    exp       = ref_result(a, b, op, w, sgn, mode, ovf);
    model_ovf = model_ovf | ovf;
    last_exp  = exp;
    apb_read(`SIMD_ADDR_RESULT, got);
    enqueue_word($sformatf("RESULT %s %s s=%b %s", op.name(), w.name(), sgn, mode.name()),
                 got, exp);
    apb_read(`SIMD_ADDR_STATUS, got);
    enqueue_flag("STATUS overflow", got[0], model_ovf);
  endtask

  task automatic clear_overflow();
    simd_word_t status;
    apb_write(`SIMD_ADDR_STATUS, 32'h1);
    model_ovf = 1'b0;
    apb_read(`SIMD_ADDR_STATUS, status);
    enqueue_flag("STATUS overflow after clear", status[0], 1'b0);
  endtask

  // Compare process that also watches the bound assertions
  initial begin : compare_results
    simd_word_t got, exp;
    logic       flag;
    string      tag;
    forever begin
      @(posedge clk_i);
      if (uut.u_regs.u_chk.fail_count != 0) begin
        $display("A protocol assertion in the register block failed");
        stop_with_failure();
      end
      while (got_q.size() > 0) begin
        got  = got_q.pop_front();
        exp  = exp_q.pop_front();
        flag = is_flag_q.pop_front();
        tag  = tag_q.pop_front();
        if (flag) begin
          check_flag(tag, got[0], exp[0]);
        end else begin
          check_word(tag, got, exp);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    simd_word_t                  a, b, rdata, eq_mask;
    logic [3:0]                  pick;
    logic [`SIMD_APB_ADDR_W-1:0] reg_addr [5];
    simd_op_e                    op;
    int                          drain;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    rst_n_i     = 1'b0;
    lcg_state   = 32'heef1;
    model_ovf   = 1'b0;
    last_slverr = 1'b0;
    last_exp    = '0;
    reg_addr    = '{`SIMD_ADDR_OPA, `SIMD_ADDR_OPB, `SIMD_ADDR_CTRL,
                    `SIMD_ADDR_RESULT, `SIMD_ADDR_STATUS};
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset values and error responses
    foreach (reg_addr[i]) begin
      apb_read(reg_addr[i], rdata);
      enqueue_word($sformatf("reset value at %h", reg_addr[i]), rdata, '0);
      enqueue_flag("pslverr on mapped read", last_slverr, 1'b0);
    end
    apb_read(8'h14, rdata);
    enqueue_flag("pslverr on unmapped read", last_slverr, 1'b1);
    apb_write(`SIMD_ADDR_RESULT, 32'hFFFF_FFFF);
    enqueue_flag("pslverr on RESULT write", last_slverr, 1'b1);
    apb_read(`SIMD_ADDR_RESULT, rdata);
    enqueue_word("RESULT after rejected write", rdata, '0);

    // Wrapping add and subtract
    for (int wi = 0; wi < 3; wi++) begin
      for (int k = 0; k < 12; k++) begin
        a = lcg_next();
        b = lcg_next();
        run_op(a, b, k[0] ? OP_SUB : OP_ADD, simd_width_e'(wi), k[1], MODE_WRAP);
      end
    end

    // Saturating with the overflow flag sticky until cleared
    for (int s = 0; s < 2; s++) begin
      for (int wi = 0; wi < 3; wi++) begin
        for (int k = 0; k < 8; k++) begin
          a = edge_word();
          b = edge_word();
          run_op(a, b, k[0] ? OP_SUB : OP_ADD, simd_width_e'(wi), s[0], MODE_SAT);
        end
      end
      clear_overflow();
    end

    // Halving
    for (int s = 0; s < 2; s++) begin
      for (int wi = 0; wi < 3; wi++) begin
        for (int k = 0; k < 6; k++) begin
          a = (k < 2) ? edge_word() : lcg_next();
          b = (k < 2) ? edge_word() : lcg_next();
          run_op(a, b, k[0] ? OP_SUB : OP_ADD, simd_width_e'(wi), s[0], MODE_HALVE);
        end
      end
    end

    // Compare and min/max where odd passes share some elements
    for (int oi = 0; oi < 4; oi++) begin
      op = simd_op_e'(int'(OP_CMPEQ) + oi);
      for (int wi = 0; wi < 2; wi++) begin
        for (int k = 0; k < 8; k++) begin
          a = lcg_next();
          b = lcg_next();
          if (k[0]) begin
            pick    = b[31:28];
            eq_mask = {{8{pick[3]}}, {8{pick[2]}}, {8{pick[1]}}, {8{pick[0]}}};
            b       = (a & eq_mask) | (lcg_next() & ~eq_mask);
          end
          run_op(a, b, op, simd_width_e'(wi), k[1], MODE_WRAP);
        end
      end
    end

    // RESULT holds across operand writes
    a = lcg_next();
    b = lcg_next();
    run_op(a, b, OP_ADD, W16, 1'b0, MODE_WRAP);
    apb_write(`SIMD_ADDR_OPA, ~a);
    apb_write(`SIMD_ADDR_OPB, ~b);
    apb_read(`SIMD_ADDR_RESULT, rdata);
    enqueue_word("RESULT after operand writes", rdata, last_exp);
    apb_read(`SIMD_ADDR_STATUS, rdata);
    enqueue_flag("STATUS done", rdata[1], 1'b1);

    drain = 0;
    while (got_q.size() > 0) begin
      drain++;
      if (drain > TIMEOUT) begin
        $display("Pending comparisons were never processed");
        stop_with_failure();
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    if (uut.u_regs.u_chk.fail_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

// File: project.f
+incdir+.
simd_pkg.sv
simd_apb_regs.sv
simd_lane_ctrl.sv
simd_byte_lane.sv
simd_result_merge.sv
simd_alu_top.sv
simd_alu_chk.sv
simd_alu_tb.sv
